//--- Bender.yml
package:
  name: u2_board

export_include_dirs:
  - logic

sources:
  - include_dirs:
      - logic
    files:
      - logic/board_io_pkg.sv
      - logic/dsp_path_pkg.sv
      - logic/adc_capture.sv
      - logic/sample_path.sv
      - logic/dac_led_drive.sv
      - logic/spi_fanout.sv
      - logic/u2_board.sv
  - target: test
    include_dirs:
      - logic
    files:
      - test/tb_u2_board.sv

//--- all.f
+incdir+logic
logic/board_io_pkg.sv
logic/dsp_path_pkg.sv
logic/adc_capture.sv
logic/sample_path.sv
logic/dac_led_drive.sv
logic/spi_fanout.sv
logic/u2_board.sv
test/tb_u2_board.sv

//--- logic/adc_capture.sv
`include "board_settings.svh"

module adc_capture (
   input  logic                     dsp_clk,
   input  logic                     rst_n_i,
   input  logic [`ADC_WIDTH-1:0]    adc_a_i,
   input  logic [`ADC_WIDTH-1:0]    adc_b_i,
   input  logic                     adc_ovf_a_i,
   input  logic                     adc_ovf_b_i,
   output board_io_pkg::adc_pins_t  adc_o
);

   board_io_pkg::adc_pins_t pad_pins;
   board_io_pkg::adc_pins_t stage1_q;   // First flop after the pads
   board_io_pkg::adc_pins_t stage2_q;

   // Gather the pad signals into one word
   always_comb
   begin
      pad_pins.adc_a = adc_a_i;
      pad_pins.adc_b = adc_b_i;
      pad_pins.ovf_a = adc_ovf_a_i;
      pad_pins.ovf_b = adc_ovf_b_i;
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         stage1_q <= '0;
         stage2_q <= '0;
      end
      else
      begin
         stage1_q <= pad_pins;
         stage2_q <= stage1_q;   // Second stage for retiming
      end
   end

   assign adc_o = stage2_q;

endmodule

//--- logic/board_io_pkg.sv
`include "board_settings.svh"

package board_io_pkg;

   // Both ADC channels as seen on the pins
   typedef struct packed {
      logic [`ADC_WIDTH-1:0] adc_a;
      logic [`ADC_WIDTH-1:0] adc_b;
      logic                  ovf_a;   // Converter overrange, channel a
      logic                  ovf_b;
   } adc_pins_t;

   // Active-low chip selects, one per device
   // Last member is bit 0, so device index 0 is the clock chip
   typedef struct packed {
      logic rx_dac;    // Index 7
      logic rx_adc;
      logic rx_db;
      logic tx_dac;
      logic tx_adc;
      logic tx_db;
      logic dac;
      logic clk;       // Index 0
   } spi_sel_n_t;

endpackage

//--- logic/board_settings.svh
`ifndef BOARD_SETTINGS_SVH
`define BOARD_SETTINGS_SVH

// ADC sample width at the pads
`define ADC_WIDTH 14

// DAC word width, also the internal sample width
`define DAC_WIDTH 16

// Peripherals sharing the serial bus
`define SPI_DEVICES 8

`endif

//--- logic/dac_led_drive.sv
`include "board_settings.svh"

module dac_led_drive (
   input  logic                        dsp_clk,
   input  logic                        rst_n_i,
   input  dsp_path_pkg::sample_pair_t  samples_i,
   input  logic                        loop_en_i,
   input  logic                        ovf_a_i,
   input  logic                        ovf_b_i,
   output logic [`DAC_WIDTH-1:0]       dac_a_o,
   output logic [`DAC_WIDTH-1:0]       dac_b_o,
   output logic [4:0]                  leds_o
);

   logic       activity;
   logic [4:0] leds_on;   // One means lit

   // Falling edge gives the DAC half a cycle of setup
   always_ff @(negedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         dac_a_o <= '0;
         dac_b_o <= '0;
      end
      else
      begin
         dac_a_o <= samples_i.a;
         dac_b_o <= samples_i.b;
      end
   end

   // Any nonzero sample on either channel
   assign activity = (|samples_i.a) | (|samples_i.b);

   assign leds_on = {1'b0, activity, ovf_b_i, ovf_a_i, loop_en_i};   // Bit 4 is link

   // Low four LEDs are wired active low
   assign leds_o = 5'b01111 ^ leds_on;

endmodule

//--- logic/dsp_path_pkg.sv
`include "board_settings.svh"

package dsp_path_pkg;

   // One sample per channel, full DAC width
   typedef struct packed {
      logic signed [`DAC_WIDTH-1:0] a;
      logic signed [`DAC_WIDTH-1:0] b;
   } sample_pair_t;

   // Top two bits of every command word
   typedef enum logic [1:0] {
      CMD_PATH    = 2'd0,   // Loop and swap config
      CMD_SPI     = 2'd1,   // Serial device select
      CMD_CLR_OVF = 2'd2    // Clear sticky overflow flags
   } cmd_kind_e;

   typedef struct packed {
      cmd_kind_e   kind;
      logic [27:0] rsvd;
      logic        loop_en;   // Bit 1
      logic        swap;      // Bit 0
   } path_cmd_t;

   typedef struct packed {
      cmd_kind_e   kind;
      logic [25:0] rsvd;
      logic [3:0]  dev_idx;   // 8 and up selects nothing
   } spi_cmd_t;

   // Same 32 bits, read by whichever block owns the kind
   typedef union packed {
      path_cmd_t path;
      spi_cmd_t  spi;
   } ctrl_word_u;

endpackage

//--- logic/sample_path.sv
`include "board_settings.svh"

module sample_path (
   input  logic                        dsp_clk,
   input  logic                        rst_n_i,
   input  board_io_pkg::adc_pins_t     adc_i,
   input  logic                        cmd_we_i,
   input  dsp_path_pkg::ctrl_word_u    cmd_i,
   output dsp_path_pkg::sample_pair_t  samples_o,
   output logic                        loop_en_o,
   output logic                        ovf_a_o,
   output logic                        ovf_b_o
);

   localparam int PAD_BITS = `DAC_WIDTH - `ADC_WIDTH;

   logic                        path_we;
   logic                        clr_ovf;
   logic                        loop_en_q;
   logic                        swap_q;
   logic                        ovf_a_q;
   logic                        ovf_b_q;
   logic signed [`DAC_WIDTH-1:0] wide_a;
   logic signed [`DAC_WIDTH-1:0] wide_b;
   dsp_path_pkg::sample_pair_t  pair_next;
   dsp_path_pkg::sample_pair_t  pair_q;

   // Only act on our own command kinds
   assign path_we = cmd_we_i && (cmd_i.path.kind == dsp_path_pkg::CMD_PATH);
   assign clr_ovf = cmd_we_i && (cmd_i.path.kind == dsp_path_pkg::CMD_CLR_OVF);

   // Left-justify into the DAC width, sign stays in the MSB
   assign wide_a = {adc_i.adc_a, {PAD_BITS{1'b0}}};
   assign wide_b = {adc_i.adc_b, {PAD_BITS{1'b0}}};

   always_comb
   begin
      pair_next = '0;   // Loop off gives silence
      if (loop_en_q)
      begin
         if (swap_q)
         begin
            pair_next.a = wide_b;
            pair_next.b = wide_a;
         end
         else
         begin
            pair_next.a = wide_a;
            pair_next.b = wide_b;
         end
      end
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         loop_en_q <= 1'b0;
         swap_q    <= 1'b0;
         ovf_a_q   <= 1'b0;
         ovf_b_q   <= 1'b0;
         pair_q    <= '0;
      end
      else
      begin
         if (path_we)
         begin
            loop_en_q <= cmd_i.path.loop_en;
            swap_q    <= cmd_i.path.swap;
         end
         // New overflow wins over a clear in the same cycle
         ovf_a_q <= adc_i.ovf_a | (ovf_a_q & ~clr_ovf);
         ovf_b_q <= adc_i.ovf_b | (ovf_b_q & ~clr_ovf);
         pair_q  <= pair_next;
      end
   end

   assign samples_o = pair_q;
   assign loop_en_o = loop_en_q;
   assign ovf_a_o   = ovf_a_q;
   assign ovf_b_o   = ovf_b_q;

endmodule

//--- logic/spi_fanout.sv
`include "board_settings.svh"

module spi_fanout (
   input  logic                      dsp_clk,
   input  logic                      rst_n_i,
   input  logic                      cmd_we_i,
   input  dsp_path_pkg::ctrl_word_u  cmd_i,
   input  logic                      spi_sclk_i,
   input  logic                      spi_mosi_i,
   input  logic [`SPI_DEVICES-1:0]   sdo_i,
   output board_io_pkg::spi_sel_n_t  sel_n_o,
   output logic [`SPI_DEVICES-1:0]   sclk_o,
   output logic [`SPI_DEVICES-1:0]   sdi_o,
   output logic                      spi_miso_o
);

   logic                    sel_we;
   logic [`SPI_DEVICES-1:0] sel_next;
   logic [`SPI_DEVICES-1:0] sel_n_q;   // Active low

   assign sel_we = cmd_we_i && (cmd_i.spi.kind == dsp_path_pkg::CMD_SPI);

   // One-hot low, out-of-range index leaves all high
   always_comb
   begin
      for (int i = 0; i < `SPI_DEVICES; i++)
      begin
         sel_next[i] = (cmd_i.spi.dev_idx != i);
      end
   end

   always_ff @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
         sel_n_q <= '1;
      else if (sel_we)
         sel_n_q <= sel_next;
   end

   assign sel_n_o = board_io_pkg::spi_sel_n_t'(sel_n_q);

   // Clock and data reach the selected device only
   assign sclk_o = {`SPI_DEVICES{spi_sclk_i}} & ~sel_n_q;
   assign sdi_o  = {`SPI_DEVICES{spi_mosi_i}} & ~sel_n_q;

   // Return data from selected devices only
   assign spi_miso_o = |(sdo_i & ~sel_n_q);

endmodule

//--- logic/u2_board.sv
`include "board_settings.svh"

module u2_board (
   input  logic                      dsp_clk,
   input  logic                      rst_n_i,
   input  logic [`ADC_WIDTH-1:0]     adc_a_i,
   input  logic [`ADC_WIDTH-1:0]     adc_b_i,
   input  logic                      adc_ovf_a_i,
   input  logic                      adc_ovf_b_i,
   input  logic                      cmd_we_i,
   input  dsp_path_pkg::ctrl_word_u  cmd_i,
   input  logic                      spi_sclk_i,
   input  logic                      spi_mosi_i,
   input  logic [`SPI_DEVICES-1:0]   sdo_i,
   output logic [`DAC_WIDTH-1:0]     dac_a_o,
   output logic [`DAC_WIDTH-1:0]     dac_b_o,
   output logic [4:0]                leds_o,
   output board_io_pkg::spi_sel_n_t  sel_n_o,
   output logic [`SPI_DEVICES-1:0]   sclk_o,
   output logic [`SPI_DEVICES-1:0]   sdi_o,
   output logic                      spi_miso_o
);

   board_io_pkg::adc_pins_t    adc_pins;   // Retimed ADC word
   dsp_path_pkg::sample_pair_t samples;
   logic                       loop_en;
   logic                       ovf_a;
   logic                       ovf_b;

   adc_capture i_adc_capture (
      .dsp_clk     (dsp_clk),
      .rst_n_i     (rst_n_i),
      .adc_a_i     (adc_a_i),
      .adc_b_i     (adc_b_i),
      .adc_ovf_a_i (adc_ovf_a_i),
      .adc_ovf_b_i (adc_ovf_b_i),
      .adc_o       (adc_pins)
   );

   sample_path i_sample_path (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .adc_i     (adc_pins),
      .cmd_we_i  (cmd_we_i),
      .cmd_i     (cmd_i),
      .samples_o (samples),
      .loop_en_o (loop_en),
      .ovf_a_o   (ovf_a),
      .ovf_b_o   (ovf_b)
   );

   dac_led_drive i_dac_led_drive (
      .dsp_clk   (dsp_clk),
      .rst_n_i   (rst_n_i),
      .samples_i (samples),
      .loop_en_i (loop_en),
      .ovf_a_i   (ovf_a),
      .ovf_b_i   (ovf_b),
      .dac_a_o   (dac_a_o),
      .dac_b_o   (dac_b_o),
      .leds_o    (leds_o)
   );

   // Same command bus as the sample path, different kind
   spi_fanout i_spi_fanout (
      .dsp_clk    (dsp_clk),
      .rst_n_i    (rst_n_i),
      .cmd_we_i   (cmd_we_i),
      .cmd_i      (cmd_i),
      .spi_sclk_i (spi_sclk_i),
      .spi_mosi_i (spi_mosi_i),
      .sdo_i      (sdo_i),
      .sel_n_o    (sel_n_o),
      .sclk_o     (sclk_o),
      .sdi_o      (sdi_o),
      .spi_miso_o (spi_miso_o)
   );

endmodule

//--- test/tb_u2_board.sv
`include "board_settings.svh"

module tb_u2_board;
   timeunit 1ns;
   timeprecision 1ps;

   localparam int CLK_PERIOD       = 8;
   localparam int RESET_CYCLES     = 16;
   localparam int RESET_CHK_CYCLES = 8;
   localparam int LOOP_CYCLES      = 64;
   localparam int SWAP_CYCLES      = 48;
   localparam int OVF_HOLD         = 12;
   localparam int SPI_CYCLES       = 16;
   localparam int MARGIN_CYCLES    = 64;
   localparam int TOTAL_CYCLES     = RESET_CYCLES + RESET_CHK_CYCLES + LOOP_CYCLES
                                     + 2 * SWAP_CYCLES + 4 * OVF_HOLD + 9 * SPI_CYCLES;
   localparam logic [4:0] LEDS_DARK = 5'b01111;   // Bits 0 to 3 active low and link off

   logic                       dsp_clk;
   logic                       rst_n_i;
   logic [`ADC_WIDTH-1:0]      adc_a_i;
   logic [`ADC_WIDTH-1:0]      adc_b_i;
   logic                       adc_ovf_a_i;
   logic                       adc_ovf_b_i;
   logic                       cmd_we_i;
   dsp_path_pkg::ctrl_word_u   cmd_i;
   logic                       spi_sclk_i;
   logic                       spi_mosi_i;
   logic [`SPI_DEVICES-1:0]    sdo_i;
   logic [`DAC_WIDTH-1:0]      dac_a_o;
   logic [`DAC_WIDTH-1:0]      dac_b_o;
   logic [4:0]                 leds_o;
   board_io_pkg::spi_sel_n_t   sel_n_o;
   logic [`SPI_DEVICES-1:0]    sclk_o;
   logic [`SPI_DEVICES-1:0]    sdi_o;
   logic                       spi_miso_o;

   // Reference model state
   board_io_pkg::adc_pins_t    pins_now;
   board_io_pkg::adc_pins_t    adc_hist [0:1];
   dsp_path_pkg::sample_pair_t exp_pair;
   logic                       m_loop;
   logic                       m_swap;
   logic                       m_ovf_a;
   logic                       m_ovf_b;
   logic [3:0]                 m_dev;   // 8 means nothing selected
   logic                       path_now;
   logic                       clr_now;
   logic                       spi_now;
   logic [31:0]                rng_state = 32'hb48218bd;
   int                         error_count = 0;
   int                         cycles_checked = 0;

   u2_board i_u2_board (.*);

   initial
   begin
      dsp_clk = 1'b0;
      forever #(CLK_PERIOD / 2) dsp_clk = ~dsp_clk;
   end

   function automatic logic [31:0] xorshift32(logic [31:0] x);
      x ^= x << 13;
      x ^= x >> 17;
      x ^= x << 5;
      return x;
   endfunction

   function automatic dsp_path_pkg::sample_pair_t expected_pair(
      board_io_pkg::adc_pins_t pins, logic loop_en, logic swap);
      dsp_path_pkg::sample_pair_t p;
      p = '0;
      if (loop_en)
      begin
         p.a = swap ? {pins.adc_b, 2'b00} : {pins.adc_a, 2'b00};
         p.b = swap ? {pins.adc_a, 2'b00} : {pins.adc_b, 2'b00};
      end
      return p;
   endfunction

   function automatic logic [4:0] expected_leds(logic loop_en, logic ovf_a, logic ovf_b,
                                                dsp_path_pkg::sample_pair_t pair);
      logic [4:0] leds;
      leds[0] = !loop_en;
      leds[1] = !ovf_a;
      leds[2] = !ovf_b;
      leds[3] = (pair.a == 0) && (pair.b == 0);   // Dark when both channels silent
      leds[4] = 1'b0;
      return leds;
   endfunction

   function automatic logic [7:0] expected_sel_n(logic [3:0] idx);
      logic [7:0] sel_n;
      sel_n = 8'hff;
      if (idx < `SPI_DEVICES)
         sel_n[idx] = 1'b0;
      return sel_n;
   endfunction

   // Bus bit routed to the selected device only
   function automatic logic [7:0] expected_fanout(logic bus_bit, logic [3:0] idx);
      logic [7:0] lines;
      lines = '0;
      if (idx < `SPI_DEVICES)
         lines[idx] = bus_bit;
      return lines;
   endfunction

   function automatic dsp_path_pkg::ctrl_word_u path_word(logic loop_en, logic swap);
      dsp_path_pkg::ctrl_word_u w;
      w = '0;
      w.path.kind    = dsp_path_pkg::CMD_PATH;
      w.path.loop_en = loop_en;
      w.path.swap    = swap;
      return w;
   endfunction

   function automatic dsp_path_pkg::ctrl_word_u spi_word(logic [3:0] idx);
      dsp_path_pkg::ctrl_word_u w;
      w = '0;
      w.spi.kind    = dsp_path_pkg::CMD_SPI;
      w.spi.dev_idx = idx;
      return w;
   endfunction

   function automatic dsp_path_pkg::ctrl_word_u clear_word();
      dsp_path_pkg::ctrl_word_u w;
      w = '0;
      w.path.kind = dsp_path_pkg::CMD_CLR_OVF;
      return w;
   endfunction

   task automatic report_error(string msg);
      error_count++;
      $display("** Error: %0t ns %s", $time, msg);
   endtask

   // One cycle of fresh random data with no command or overflow
   task automatic drive_cycle();
      @(posedge dsp_clk);
      #1;
      cmd_we_i    = 1'b0;
      adc_ovf_a_i = 1'b0;
      adc_ovf_b_i = 1'b0;
      rng_state   = xorshift32(rng_state);
      adc_a_i     = rng_state[13:0];
      adc_b_i     = rng_state[27:14];
      rng_state   = xorshift32(rng_state);
      sdo_i       = rng_state[7:0];
      spi_sclk_i  = rng_state[8];
      spi_mosi_i  = rng_state[9];
   endtask

   task automatic run_idle(int n);
      repeat (n) drive_cycle();
   endtask

   task automatic write_cmd(dsp_path_pkg::ctrl_word_u w);
      drive_cycle();
      cmd_we_i = 1'b1;
      cmd_i    = w;
   endtask

   always_comb
   begin
      pins_now.adc_a = adc_a_i;
      pins_now.adc_b = adc_b_i;
      pins_now.ovf_a = adc_ovf_a_i;
      pins_now.ovf_b = adc_ovf_b_i;
   end

   assign path_now = cmd_we_i && (cmd_i.path.kind == dsp_path_pkg::CMD_PATH);
   assign clr_now  = cmd_we_i && (cmd_i.path.kind == dsp_path_pkg::CMD_CLR_OVF);
   assign spi_now  = cmd_we_i && (cmd_i.spi.kind == dsp_path_pkg::CMD_SPI);

   always @(posedge dsp_clk or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         adc_hist[0] <= '0;
         adc_hist[1] <= '0;
         exp_pair    <= '0;
         m_loop      <= 1'b0;
         m_swap      <= 1'b0;
         m_ovf_a     <= 1'b0;
         m_ovf_b     <= 1'b0;
         m_dev       <= 4'd8;
      end
      else
      begin
         adc_hist[0] <= pins_now;
         adc_hist[1] <= adc_hist[0];   // Two pad stages
         exp_pair    <= expected_pair(adc_hist[1], m_loop, m_swap);
         if (adc_hist[1].ovf_a)
            m_ovf_a <= 1'b1;
         else if (clr_now)
            m_ovf_a <= 1'b0;
         if (adc_hist[1].ovf_b)
            m_ovf_b <= 1'b1;
         else if (clr_now)
            m_ovf_b <= 1'b0;
         if (path_now)
         begin
            m_loop <= cmd_i.path.loop_en;
            m_swap <= cmd_i.path.swap;
         end
         if (spi_now)
            m_dev <= cmd_i.spi.dev_idx;
         cycles_checked++;
      end
   end

   a_reset_state: assert property (@(posedge dsp_clk) $rose(rst_n_i) |->
      (sel_n_o == 8'hff && sclk_o == '0 && sdi_o == '0 && dac_a_o == '0
       && dac_b_o == '0 && leds_o == LEDS_DARK))
      else report_error("outputs not in their reset state after reset");

   a_dac: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      dac_a_o == exp_pair.a && dac_b_o == exp_pair.b)
      else report_error($sformatf("DAC words %h %h, expected %h %h", $sampled(dac_a_o),
                                  $sampled(dac_b_o), $sampled(exp_pair.a),
                                  $sampled(exp_pair.b)));

   // DAC still shows the previous sample until the falling edge
   a_dac_fall: assert property (@(negedge dsp_clk) disable iff (!rst_n_i)
      dac_a_o == $past(exp_pair.a) && dac_b_o == $past(exp_pair.b))
      else report_error("DAC words changed before the falling edge");

   a_leds: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      leds_o == expected_leds(m_loop, m_ovf_a, m_ovf_b, exp_pair))
      else report_error($sformatf("LEDs %b differ from the model", $sampled(leds_o)));

   // Sticky overflow holds while no clear arrives
   a_ovf_hold: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      (!leds_o[1] && !clr_now) |=> !leds_o[1])
      else report_error("overflow a LED went dark without a clear");

   a_ovf_race: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      (clr_now && adc_hist[1].ovf_b) |=> !leds_o[2])
      else report_error("overflow b lost when it met a clear");

   a_sel: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      sel_n_o == expected_sel_n(m_dev))
      else report_error($sformatf("selects %b, device index %0d", $sampled(sel_n_o),
                                  $sampled(m_dev)));

   a_gating: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      sclk_o == expected_fanout(spi_sclk_i, m_dev)
      && sdi_o == expected_fanout(spi_mosi_i, m_dev))
      else report_error("device clock or data not gated to the selected device");

   a_miso: assert property (@(posedge dsp_clk) disable iff (!rst_n_i)
      spi_miso_o == ((m_dev < `SPI_DEVICES) ? sdo_i[m_dev[2:0]] : 1'b0))
      else report_error("return data does not match the selected device");

   initial
   begin
      rst_n_i     = 1'b0;
      adc_a_i     = '0;
      adc_b_i     = '0;
      adc_ovf_a_i = 1'b0;
      adc_ovf_b_i = 1'b0;
      cmd_we_i    = 1'b0;
      cmd_i       = '0;
      spi_sclk_i  = 1'b0;
      spi_mosi_i  = 1'b0;
      sdo_i       = '0;
      repeat (RESET_CYCLES) @(posedge dsp_clk);
      #1 rst_n_i = 1'b1;
      run_idle(RESET_CHK_CYCLES);   // Loop still off
      write_cmd(path_word(1'b1, 1'b0));
      run_idle(LOOP_CYCLES);
      write_cmd(path_word(1'b1, 1'b1));
      run_idle(SWAP_CYCLES);
      write_cmd(path_word(1'b0, 1'b1));   // Back to silence
      run_idle(SWAP_CYCLES);
      write_cmd(path_word(1'b1, 1'b0));
      drive_cycle();
      adc_ovf_a_i = 1'b1;
      run_idle(OVF_HOLD);
      write_cmd(clear_word());
      run_idle(OVF_HOLD);
      drive_cycle();
      adc_ovf_b_i = 1'b1;
      drive_cycle();
      write_cmd(clear_word());   // Meets the overflow at the flag
      run_idle(OVF_HOLD);
      write_cmd(clear_word());
      run_idle(OVF_HOLD);
      for (int idx = 0; idx <= 9; idx++)
      begin
         if (idx == 8)
            continue;
         write_cmd(spi_word(4'(idx)));
         run_idle(SPI_CYCLES);
      end
      run_idle(4);
      $display("Summary: %0d errors in %0d checked cycles", error_count, cycles_checked);
      if (error_count == 0)
         $display("all tests passed");
      else
         $display("tests failed");
      $finish;
   end

   initial
   begin
      #((TOTAL_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Watchdog expired, the stimulus hung before reaching its end");
      $display("Summary: %0d errors in %0d checked cycles", error_count, cycles_checked);
      $display("tests failed");
      $finish;
   end

endmodule
